/* rtl/clock_pkg.sv */
package clock_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	// One time unit, 0 to 59
	typedef logic [5:0] unit_t;
	typedef logic [3:0] digit_t;
	// Segments a..g, a in the MSB, 1 is lit
	typedef logic [6:0] seg_t;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	// ------------------------------
	// Limits and display
	// ------------------------------
	// Minutes wrap at the same limit as seconds
	localparam unit_t SEC_MAX  = 6'd59;
	localparam unit_t HOUR_MAX = 6'd23;
	localparam int NUM_DIGITS = 6;

	// Patterns for 0 to 9
	localparam seg_t SEG_TABLE [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage

/* rtl/tick_gen.sv */
module tick_gen #(
	parameter int DIV = 1000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt;

	// Counts down from DIV-1, reload on zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= CNT_W'(DIV - 1);
		end else if (cnt == '0) begin
			cnt <= CNT_W'(DIV - 1);
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign o_tick = (cnt == '0);

endmodule

/* rtl/key_sync.sv */
module key_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_tick,
	input  logic i_key_mode,
	input  logic i_key_pos,
	input  logic i_key_inc,
	input  logic i_key_alarm,
	output logic o_press_mode,
	output logic o_press_pos,
	output logic o_press_inc,
	output logic o_press_alarm
);

	logic [3:0] keys;
	logic [3:0] samp_new;
	logic [3:0] samp_old;
	logic [3:0] rise;

	assign keys = {i_key_alarm, i_key_inc, i_key_pos, i_key_mode};

	// Slow sampling filters out bounce shorter than one tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_new <= '0;
			samp_old <= '0;
		end else if (i_tick) begin
			samp_new <= keys;
			samp_old <= samp_new;
		end
	end

	// Low then high between samples, one cycle wide
	assign rise = samp_new & ~samp_old & {4{i_tick}};

	assign o_press_mode  = rise[0];
	assign o_press_pos   = rise[1];
	assign o_press_inc   = rise[2];
	assign o_press_alarm = rise[3];

endmodule

/* rtl/clock_ctrl.sv */
module clock_ctrl import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_sec_tick,
	input  logic  i_press_mode,
	input  logic  i_press_pos,
	input  logic  i_press_inc,
	input  logic  i_press_alarm,
	output mode_t o_mode,
	output logic  o_alarm_en,
	output logic  o_inc_sec,
	output logic  o_inc_min,
	output logic  o_inc_hour,
	output logic  o_inc_alarm_sec,
	output logic  o_inc_alarm_min,
	output logic  o_inc_alarm_hour
);

	pos_t pos;
	logic run;
	logic set_time;
	logic set_alarm;

	// ------------------------------
	// Mode, position, alarm enable
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press_mode) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= POS_SEC;
		end else if (i_press_pos) begin
			case (pos)
				POS_SEC: pos <= POS_MIN;
				POS_MIN: pos <= POS_HOUR;
				default: pos <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_press_alarm) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// ------------------------------
	// Strobe steering
	// ------------------------------
	// Time is frozen only while it is being set
	assign run       = i_sec_tick && (o_mode != MODE_SETUP);
	assign set_time  = i_press_inc && (o_mode == MODE_SETUP);
	assign set_alarm = i_press_inc && (o_mode == MODE_ALARM);

	assign o_inc_sec        = run || (set_time && pos == POS_SEC);
	assign o_inc_min        = set_time && (pos == POS_MIN);
	assign o_inc_hour       = set_time && (pos == POS_HOUR);
	assign o_inc_alarm_sec  = set_alarm && (pos == POS_SEC);
	assign o_inc_alarm_min  = set_alarm && (pos == POS_MIN);
	assign o_inc_alarm_hour = set_alarm && (pos == POS_HOUR);

endmodule

/* rtl/time_counter.sv */
module time_counter import clock_pkg::*; #(
	parameter bit CARRY = 1'b1
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_inc_sec,
	input  logic  i_inc_min,
	input  logic  i_inc_hour,
	output unit_t o_sec,
	output unit_t o_min,
	output unit_t o_hour
);

	logic sec_wrap;
	logic min_step;
	logic min_wrap;
	logic hour_step;

	function automatic unit_t wrap_inc(input unit_t value, input unit_t limit);
		if (value >= limit) begin
			return '0;
		end
		return value + 6'd1;
	endfunction

	// Carry ripples through in the same cycle
	assign sec_wrap  = i_inc_sec && (o_sec >= SEC_MAX);
	assign min_step  = i_inc_min || (CARRY && sec_wrap);
	assign min_wrap  = min_step && (o_min >= SEC_MAX);
	assign hour_step = i_inc_hour || (CARRY && min_wrap);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else begin
			if (i_inc_sec)
				o_sec <= wrap_inc(o_sec, SEC_MAX);
			if (min_step)
				o_min <= wrap_inc(o_min, SEC_MAX);
			if (hour_step)
				o_hour <= wrap_inc(o_hour, HOUR_MAX);
		end
	end

endmodule

/* rtl/alarm_match.sv */
module alarm_match import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_alarm_en,
	input  unit_t i_sec,
	input  unit_t i_min,
	input  unit_t i_hour,
	input  unit_t i_alarm_sec,
	input  unit_t i_alarm_min,
	input  unit_t i_alarm_hour,
	output logic  o_alarm
);

	logic match;

	assign match = (i_sec == i_alarm_sec) && (i_min == i_alarm_min) &&
		(i_hour == i_alarm_hour);

	// Set on match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en && (match || o_alarm);
		end
	end

endmodule

/* rtl/seg_scan.sv */
module seg_scan import clock_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan_tick,
	input  mode_t                 i_mode,
	input  unit_t                 i_sec,
	input  unit_t                 i_min,
	input  unit_t                 i_hour,
	input  unit_t                 i_alarm_sec,
	input  unit_t                 i_alarm_min,
	input  unit_t                 i_alarm_hour,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic [IDX_W-1:0] idx;
	logic [1:0]       mode_bits;
	unit_t            show_sec;
	unit_t            show_min;
	unit_t            show_hour;
	digit_t           digits [NUM_DIGITS];
	digit_t           cur_digit;

	// ------------------------------
	// Scan index
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (i_scan_tick) begin
			if (idx == IDX_W'(NUM_DIGITS - 1))
				idx <= '0;
			else
				idx <= idx + 1'b1;
		end
	end

	// ------------------------------
	// Digit selection and decode
	// ------------------------------
	// Alarm mode shows the alarm time
	assign show_sec  = (i_mode == MODE_ALARM) ? i_alarm_sec  : i_sec;
	assign show_min  = (i_mode == MODE_ALARM) ? i_alarm_min  : i_min;
	assign show_hour = (i_mode == MODE_ALARM) ? i_alarm_hour : i_hour;

	// Digit 0 is seconds ones, digit 5 hours tens
	always_comb begin
		digits[0] = digit_t'(show_sec % 6'd10);
		digits[1] = digit_t'(show_sec / 6'd10);
		digits[2] = digit_t'(show_min % 6'd10);
		digits[3] = digit_t'(show_min / 6'd10);
		digits[4] = digit_t'(show_hour % 6'd10);
		digits[5] = digit_t'(show_hour / 6'd10);
	end

	assign cur_digit = digits[idx];
	assign o_seg     = (cur_digit <= 4'd9) ? SEG_TABLE[cur_digit] : '0;

	// Active low, one digit at a time
	assign o_seg_enb = ~(NUM_DIGITS'(1) << idx);

	assign mode_bits = i_mode;
	assign o_seg_dp  = (idx == IDX_W'(0)) ? mode_bits[0] :
		(idx == IDX_W'(1)) ? mode_bits[1] : 1'b0;

endmodule

/* rtl/clock_top.sv */
module clock_top import clock_pkg::*; #(
	parameter int SEC_DIV  = 50_000_000,
	parameter int SCAN_DIV = 50_000,
	parameter int KEY_DIV  = 500_000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_key_mode,
	input  logic                  i_key_pos,
	input  logic                  i_key_inc,
	input  logic                  i_key_alarm,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic  sec_tick, scan_tick, key_tick;
	logic  press_mode, press_pos, press_inc, press_alarm;
	mode_t mode;
	logic  alarm_en;
	logic  inc_sec, inc_min, inc_hour;
	logic  inc_alarm_sec, inc_alarm_min, inc_alarm_hour;
	unit_t sec, min, hour;
	unit_t alarm_sec, alarm_min, alarm_hour;

	// ------------------------------
	// Tick enables
	// ------------------------------
	tick_gen #(.DIV(SEC_DIV))  u_sec_tick  (.clk, .rst_n, .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk, .rst_n, .o_tick(scan_tick));
	tick_gen #(.DIV(KEY_DIV))  u_key_tick  (.clk, .rst_n, .o_tick(key_tick));

	// ------------------------------
	// Keys and control
	// ------------------------------
	key_sync u_key_sync (
		.clk, .rst_n, .i_tick(key_tick),
		.i_key_mode, .i_key_pos, .i_key_inc, .i_key_alarm,
		.o_press_mode(press_mode), .o_press_pos(press_pos),
		.o_press_inc(press_inc), .o_press_alarm(press_alarm)
	);

	clock_ctrl u_clock_ctrl (
		.clk, .rst_n, .i_sec_tick(sec_tick),
		.i_press_mode(press_mode), .i_press_pos(press_pos),
		.i_press_inc(press_inc), .i_press_alarm(press_alarm),
		.o_mode(mode), .o_alarm_en(alarm_en),
		.o_inc_sec(inc_sec), .o_inc_min(inc_min), .o_inc_hour(inc_hour),
		.o_inc_alarm_sec(inc_alarm_sec), .o_inc_alarm_min(inc_alarm_min),
		.o_inc_alarm_hour(inc_alarm_hour)
	);

	// Running time carries, alarm units are set one by one
	time_counter #(.CARRY(1'b1)) u_time (
		.clk, .rst_n, .i_inc_sec(inc_sec), .i_inc_min(inc_min), .i_inc_hour(inc_hour),
		.o_sec(sec), .o_min(min), .o_hour(hour)
	);

	time_counter #(.CARRY(1'b0)) u_alarm (
		.clk, .rst_n, .i_inc_sec(inc_alarm_sec), .i_inc_min(inc_alarm_min),
		.i_inc_hour(inc_alarm_hour),
		.o_sec(alarm_sec), .o_min(alarm_min), .o_hour(alarm_hour)
	);

	alarm_match u_alarm_match (
		.clk, .rst_n, .i_alarm_en(alarm_en),
		.i_sec(sec), .i_min(min), .i_hour(hour),
		.i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hour(alarm_hour),
		.o_alarm
	);

	seg_scan u_seg_scan (
		.clk, .rst_n, .i_scan_tick(scan_tick), .i_mode(mode),
		.i_sec(sec), .i_min(min), .i_hour(hour),
		.i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hour(alarm_hour),
		.o_seg, .o_seg_dp, .o_seg_enb
	);

endmodule

/* verif/tb_clock.sv */
module tb_clock import clock_pkg::*; ();

	localparam int SEC_DIV      = 4000;
	localparam int SCAN_DIV     = 2;
	localparam int KEY_DIV      = 4;
	localparam int PRESS_CYCLES = 20;

	localparam int KEY_MODE  = 0;
	localparam int KEY_POS   = 1;
	localparam int KEY_INC   = 2;
	localparam int KEY_ALARM = 3;

	typedef enum int {ACT_PRESS, ACT_WAIT, ACT_DISP, ACT_ALARM, ACT_AHEAD, ACT_MATCH} act_t;

	logic                  clk;
	logic                  rst_n;
	logic [3:0]            keys;
	seg_t                  o_seg;
	logic                  o_seg_dp;
	logic [NUM_DIGITS-1:0] o_seg_enb;
	logic                  o_alarm;

	// Stimulus table with one action per row
	act_t   tab_act [64];
	int     tab_arg [64];
	int     tab_cnt [64];
	int     num_steps;
	integer seed;
	int     cycles;
	int     limit;

	// Reference model state
	int         cyc;
	logic [3:0] m_new;
	logic [3:0] m_old;
	logic [3:0] m_press;
	mode_t      m_mode;
	pos_t       m_pos;
	logic       m_en;
	int         m_time [3];
	int         m_alm [3];

	clock_top #(.SEC_DIV(SEC_DIV), .SCAN_DIV(SCAN_DIV), .KEY_DIV(KEY_DIV)) DUT (
		.clk, .rst_n,
		.i_key_mode(keys[KEY_MODE]), .i_key_pos(keys[KEY_POS]),
		.i_key_inc(keys[KEY_INC]), .i_key_alarm(keys[KEY_ALARM]),
		.o_seg, .o_seg_dp, .o_seg_enb, .o_alarm
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic int unit_mod(input int u);
		return (u == 2) ? int'(HOUR_MAX) + 1 : int'(SEC_MAX) + 1;
	endfunction

	function automatic int pick_count(input int lo, input int span);
		return lo + int'($unsigned($random(seed)) % span);
	endfunction

	function automatic bit time_matches();
		return (m_time[0] == m_alm[0]) && (m_time[1] == m_alm[1]) && (m_time[2] == m_alm[2]);
	endfunction

	// One step of the running time with ripple carry upwards
	task automatic advance_time(input int unit);
		int u;
		u = unit;
		m_time[u]++;
		while (u < 2 && m_time[u] == unit_mod(u)) begin
			m_time[u] = 0;
			u++;
			m_time[u]++;
		end
		if (m_time[2] == unit_mod(2))
			m_time[2] = 0;
	endtask

	task automatic add_step(input act_t act, input int arg, input int cnt);
		tab_act[num_steps] = act;
		tab_arg[num_steps] = arg;
		tab_cnt[num_steps] = cnt;
		num_steps++;
	endtask

	function automatic int step_budget(input int i);
		case (tab_act[i])
			ACT_PRESS: return tab_cnt[i] * PRESS_CYCLES;
			ACT_WAIT:  return tab_arg[i];
			ACT_MATCH: return tab_arg[i];
			ACT_AHEAD: return (2 * (int'(SEC_MAX) + 1) + int'(HOUR_MAX) + 4) * PRESS_CYCLES;
			default:   return 0;
		endcase
	endfunction

	// ------------------------------
	// Reference model
	// ------------------------------
	// Ticks land on edges DIV, 2*DIV and so on after reset release
	always @(posedge clk) begin
		if (!rst_n) begin
			cyc = 0;
			m_new = '0;
			m_old = '0;
			m_mode = MODE_CLOCK;
			m_pos = POS_SEC;
			m_en = 1'b0;
			m_time = '{0, 0, 0};
			m_alm = '{0, 0, 0};
		end else begin
			cyc++;
			m_press = '0;
			if (cyc % KEY_DIV == 0) begin
				m_press = m_new & ~m_old;
				m_old = m_new;
				m_new = keys;
			end
			if (cyc % SEC_DIV == 0 && m_mode != MODE_SETUP)
				advance_time(0);
			if (m_press[KEY_INC] && m_mode == MODE_SETUP)
				advance_time(int'(m_pos));
			if (m_press[KEY_INC] && m_mode == MODE_ALARM)
				m_alm[int'(m_pos)] = (m_alm[int'(m_pos)] + 1) % unit_mod(int'(m_pos));
			if (m_press[KEY_MODE])
				m_mode = (m_mode == MODE_CLOCK) ? MODE_SETUP :
					(m_mode == MODE_SETUP) ? MODE_ALARM : MODE_CLOCK;
			if (m_press[KEY_POS])
				m_pos = (m_pos == POS_SEC) ? POS_MIN : (m_pos == POS_MIN) ? POS_HOUR : POS_SEC;
			if (m_press[KEY_ALARM])
				m_en = !m_en;
		end
	end

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic end_with_failure();
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_seg(input seg_t got, input seg_t exp, input int digit);
		if (got !== exp) begin
			$display("FAIL o_seg digit %0d: got %h, expected %h", digit, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_dp(input logic got, input logic exp, input int digit);
		if (got !== exp) begin
			$display("FAIL o_seg_dp digit %0d: got %h, expected %h", digit, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_alarm(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL o_alarm: got %h, expected %h", got, exp);
			end_with_failure();
		end
	endtask

	// ------------------------------
	// Actions
	// ------------------------------
	task automatic press_key(input int key, input int times);
		repeat (times) begin
			@(posedge clk);
			keys[key] <= 1'b1;
			repeat (PRESS_CYCLES / 2) @(posedge clk);
			keys[key] <= 1'b0;
			repeat (PRESS_CYCLES / 2 - 1) @(posedge clk);
		end
	endtask

	// Reads each digit while its enable is low
	task automatic check_display();
		logic [NUM_DIGITS-1:0] enb_exp;
		logic [1:0]            mode_bits;
		int                    val;
		digit_t                dig;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			enb_exp = '1;
			enb_exp[d] = 1'b0;
			@(negedge clk);
			while (o_seg_enb !== enb_exp)
				@(negedge clk);
			val = (m_mode == MODE_ALARM) ? m_alm[d / 2] : m_time[d / 2];
			dig = digit_t'((d % 2 == 0) ? val % 10 : val / 10);
			mode_bits = m_mode;
			check_seg(o_seg, SEG_TABLE[dig], d);
			check_dp(o_seg_dp, (d < 2) ? mode_bits[d] : 1'b0, d);
		end
	endtask

	// Alarm target is the model time plus a few seconds with full carry
	task automatic set_alarm_ahead(input int secs);
		int target [3];
		int n;
		target = m_time;
		target[0] += secs;
		for (int u = 0; u < 2; u++) begin
			if (target[u] >= unit_mod(u)) begin
				target[u] -= unit_mod(u);
				target[u + 1]++;
			end
		end
		if (target[2] >= unit_mod(2))
			target[2] -= unit_mod(2);
		for (int u = 0; u < 3; u++) begin
			n = (target[u] - m_alm[u] + unit_mod(u)) % unit_mod(u);
			press_key(KEY_INC, n);
			press_key(KEY_POS, 1);
		end
	endtask

	task automatic apply_step(input int i);
		case (tab_act[i])
			ACT_PRESS: press_key(tab_arg[i], tab_cnt[i]);
			ACT_WAIT:  repeat (tab_arg[i]) @(posedge clk);
			ACT_DISP:  check_display();
			ACT_AHEAD: set_alarm_ahead(tab_arg[i]);
			ACT_ALARM: begin
				@(negedge clk);
				check_alarm(o_alarm, tab_arg[i][0]);
			end
			// Low on the match cycle itself and up one edge later when enabled
			ACT_MATCH: begin
				@(negedge clk);
				while (!time_matches())
					@(negedge clk);
				check_alarm(o_alarm, 1'b0);
				@(negedge clk);
				check_alarm(o_alarm, m_en);
			end
			default: ;
		endcase
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", limit);
			end_with_failure();
		end
	end

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		rst_n = 1'b0;
		keys = '0;
		seed = 32'hf26443d3;
		num_steps = 0;
		cycles = 0;

		// Reset state
		add_step(ACT_DISP, 0, 0);
		add_step(ACT_ALARM, 0, 0);
		// Setup with a seconds wrap that carries into minutes
		add_step(ACT_PRESS, KEY_MODE, 1);
		add_step(ACT_PRESS, KEY_INC, pick_count(60, 12));
		add_step(ACT_PRESS, KEY_POS, 1);
		add_step(ACT_PRESS, KEY_INC, pick_count(1, 70));
		add_step(ACT_PRESS, KEY_POS, 1);
		add_step(ACT_PRESS, KEY_INC, pick_count(20, 10));
		add_step(ACT_PRESS, KEY_POS, 1);
		add_step(ACT_DISP, 0, 0);
		add_step(ACT_WAIT, 3 * SEC_DIV, 0);
		add_step(ACT_DISP, 0, 0);
		// Back to clock mode and run
		add_step(ACT_PRESS, KEY_MODE, 2);
		add_step(ACT_DISP, 0, 0);
		add_step(ACT_WAIT, 3 * SEC_DIV, 0);
		add_step(ACT_DISP, 0, 0);
		// Alarm mode sets units without carry
		add_step(ACT_PRESS, KEY_MODE, 2);
		add_step(ACT_DISP, 0, 0);
		add_step(ACT_PRESS, KEY_INC, pick_count(60, 12));
		add_step(ACT_DISP, 0, 0);
		add_step(ACT_PRESS, KEY_POS, 1);
		add_step(ACT_PRESS, KEY_INC, pick_count(1, 70));
		add_step(ACT_PRESS, KEY_POS, 1);
		add_step(ACT_PRESS, KEY_INC, pick_count(1, 30));
		add_step(ACT_PRESS, KEY_POS, 1);
		add_step(ACT_DISP, 0, 0);
		// Alarm firing
		add_step(ACT_AHEAD, 5, 0);
		add_step(ACT_DISP, 0, 0);
		add_step(ACT_PRESS, KEY_MODE, 1);
		add_step(ACT_PRESS, KEY_ALARM, 1);
		add_step(ACT_ALARM, 0, 0);
		add_step(ACT_MATCH, 6 * SEC_DIV, 0);
		add_step(ACT_WAIT, 2 * SEC_DIV, 0);
		add_step(ACT_ALARM, 1, 0);
		add_step(ACT_DISP, 0, 0);
		add_step(ACT_PRESS, KEY_ALARM, 1);
		add_step(ACT_ALARM, 0, 0);

		limit = 2000;
		for (int i = 0; i < num_steps; i++)
			limit += step_budget(i);

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < num_steps; i++)
			apply_step(i);

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* verilog.f */
rtl/clock_pkg.sv
rtl/tick_gen.sv
rtl/key_sync.sv
rtl/clock_ctrl.sv
rtl/time_counter.sv
rtl/alarm_match.sv
rtl/seg_scan.sv
rtl/clock_top.sv
verif/tb_clock.sv

/* Bender.yml */
package:
  name: digital_clock

sources:
  - rtl/clock_pkg.sv
  - rtl/tick_gen.sv
  - rtl/key_sync.sv
  - rtl/clock_ctrl.sv
  - rtl/time_counter.sv
  - rtl/alarm_match.sv
  - rtl/seg_scan.sv
  - rtl/clock_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
